//--- include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// memory sizes
`define IMEM_WORDS 256  // instruction words
`define DMEM_BYTES 256  // data bytes, addresses wrap here

// major opcodes of the supported subset
`define OP_R      7'b011_0011  // add, sub, mul
`define OP_IMM    7'b001_0011  // addi
`define OP_LOAD   7'b000_0011  // lw
`define OP_STORE  7'b010_0011  // sw
`define OP_BRANCH 7'b110_0011  // blt
`define OP_LUI    7'b011_0111

// funct fields
`define F7_SUB   7'b010_0000
`define F7_MUL   7'b000_0001
`define F3_LW_SW 3'b010
`define F3_BLT   3'b100

`define END_WORD 32'hFFFF_FFFF  // end of program marker
`endif

//--- hw/riscvPkg.sv
package riscvPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;  // upper 20 bits of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    // one instruction word, viewed per format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
    } instrT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluMul,
        aluLui,
        aluNone  // branches, no result
    } aluOpT;

endpackage

//--- hw/fetchStage.sv
`timescale 1ns/1ns
`include "core_consts.svh"

module fetchStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             retire,
    input  logic             takeBranch,
    input  logic [31:0]      branchTarget,
    input  logic             imemWe,
    input  logic [7:0]       imemAddr,
    input  logic [31:0]      imemData,
    output logic             fetchValid,
    output riscvPkg::instrT  instr,
    output logic [31:0]      pc
);
    import riscvPkg::*;

    localparam int idxW = $clog2(`IMEM_WORDS);

    instrT       imem [0:`IMEM_WORDS-1];  // word addressed
    logic [31:0] nextPc;
    logic        tokenLive;  // a token is somewhere in the ring

    // start always goes to 0, otherwise redirect or fall through
    assign nextPc = start ? 32'd0 : (takeBranch ? branchTarget : pc + 32'd4);

    // loader port
    always_ff @(posedge clk) begin
        if (imemWe) imem[imemAddr] <= imemData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= 32'd0;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= start || retire;  // one pulse per issue
            if (start || retire) pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (start || retire) instr <= imem[nextPc[idxW+1:2]];
    end

    // end word dies in decode and never retires
    always_ff @(posedge clk) begin
        if (rst) tokenLive <= 1'b0;
        else if (start || retire) tokenLive <= 1'b1;
        else if (fetchValid && instr == `END_WORD) tokenLive <= 1'b0;
    end

    // loading while a program runs would corrupt the token's next fetch
    assert property (@(posedge clk) disable iff (rst) imemWe |-> !tokenLive);

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/1ns
`include "core_consts.svh"

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetchValid,
    input  riscvPkg::instrT  instr,
    input  logic [31:0]      pc,
    input  logic             wbEn,
    input  logic [4:0]       wbRd,
    input  logic [31:0]      wbData,
    input  logic [4:0]       dbgAddr,
    output logic [31:0]      dbgData,
    output logic             decValid,
    output logic             endSeen,
    output riscvPkg::aluOpT  aluOp,
    output logic [31:0]      opA,
    output logic [31:0]      opB,
    output logic [31:0]      storeData,
    output logic [4:0]       rd,
    output logic             isLoad,
    output logic             isStore,
    output logic             isBranch,
    output logic [31:0]      branchTarget
);
    import riscvPkg::*;

    logic [31:0] regs [0:31];
    logic [31:0] rs1Val, rs2Val;
    logic [31:0] immI, immS, immB, immU;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    aluOpT       aluOpNext;
    logic [31:0] opBNext;
    logic [4:0]  rdNext;
    logic        isLoadNext, isStoreNext, isBranchNext;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.iType.funct3;  // same bits in every view that has one

    // x0 hardwired to zero
    assign rs1Val  = (instr.rType.rs1 == 5'd0) ? 32'd0 : regs[instr.rType.rs1];
    assign rs2Val  = (instr.rType.rs2 == 5'd0) ? 32'd0 : regs[instr.rType.rs2];
    assign dbgData = (dbgAddr == 5'd0) ? 32'd0 : regs[dbgAddr];

    // sign extended immediates
    assign immI = {{20{instr.iType.imm[11]}}, instr.iType.imm};
    assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
    assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                   instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
    assign immU = {instr.uType.imm, 12'd0};

    always_comb begin
        aluOpNext    = aluNone;
        opBNext      = rs2Val;
        rdNext       = 5'd0;  // no write unless decoded below
        isLoadNext   = 1'b0;
        isStoreNext  = 1'b0;
        isBranchNext = 1'b0;
        case (opcode)
            `OP_R: begin
                rdNext = instr.rType.rd;
                if (instr.rType.funct7 == `F7_SUB) aluOpNext = aluSub;
                else if (instr.rType.funct7 == `F7_MUL) aluOpNext = aluMul;
                else aluOpNext = aluAdd;
            end
            `OP_IMM: begin
                aluOpNext = aluAdd;
                opBNext   = immI;
                rdNext    = instr.rType.rd;
            end
            `OP_LOAD: if (funct3 == `F3_LW_SW) begin
                aluOpNext  = aluAdd;  // effective address
                opBNext    = immI;
                rdNext     = instr.rType.rd;
                isLoadNext = 1'b1;
            end
            `OP_STORE: if (funct3 == `F3_LW_SW) begin
                aluOpNext   = aluAdd;
                opBNext     = immS;  // rd field holds offset bits here
                isStoreNext = 1'b1;
            end
            `OP_BRANCH: isBranchNext = (funct3 == `F3_BLT);  // compare rs1, rs2
            `OP_LUI: begin
                aluOpNext = aluLui;
                opBNext   = immU;
                rdNext    = instr.uType.rd;
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= 32'd0;
        end else if (wbEn) begin
            regs[wbRd] <= wbData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
            endSeen  <= 1'b0;
        end else begin
            decValid <= fetchValid && (instr != `END_WORD);
            endSeen  <= fetchValid && (instr == `END_WORD);  // token stops here
        end
    end

    // payload, qualified by decValid
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            aluOp        <= aluOpNext;
            opA          <= rs1Val;
            opB          <= opBNext;
            storeData    <= rs2Val;
            rd           <= rdNext;
            isLoad       <= isLoadNext;
            isStore      <= isStoreNext;
            isBranch     <= isBranchNext;
            branchTarget <= pc + immB;  // pc of this instruction
        end
    end

    // memStage owns the x0 filter, decode only ever sees real writes
    assert property (@(posedge clk) disable iff (rst) wbEn |-> wbRd != 5'd0);

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             decValid,
    input  riscvPkg::aluOpT  aluOp,
    input  logic [31:0]      opA,
    input  logic [31:0]      opB,
    input  logic [31:0]      storeDataIn,
    input  logic [4:0]       rdIn,
    input  logic             isLoadIn,
    input  logic             isStoreIn,
    input  logic             isBranchIn,
    input  logic [31:0]      branchTargetIn,
    output logic             exValid,
    output logic [31:0]      result,
    output logic [31:0]      storeData,
    output logic [4:0]       rd,
    output logic             isLoad,
    output logic             isStore,
    output logic             takeBranch,
    output logic [31:0]      branchTarget
);
    import riscvPkg::*;

    logic [31:0] aluOut;
    logic [31:0] product;
    logic        lessThan;

    assign product  = opA * opB;  // only the low word is kept
    assign lessThan = $signed(opA) < $signed(opB);  // blt is signed

    always_comb begin
        case (aluOp)
            aluAdd:  aluOut = opA + opB;  // also load/store address
            aluSub:  aluOut = opA - opB;
            aluMul:  aluOut = product;
            aluLui:  aluOut = opB;  // immediate already shifted
            default: aluOut = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) exValid <= 1'b0;
        else exValid <= decValid;
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            result       <= aluOut;
            storeData    <= storeDataIn;
            rd           <= rdIn;
            isLoad       <= isLoadIn;
            isStore      <= isStoreIn;
            takeBranch   <= isBranchIn && lessThan;
            branchTarget <= branchTargetIn;
        end
    end

endmodule

//--- hw/memStage.sv
`timescale 1ns/1ns
`include "core_consts.svh"

module memStage (
    input  logic        clk,
    input  logic        rst,
    input  logic        exValid,
    input  logic [31:0] result,
    input  logic [31:0] storeData,
    input  logic [4:0]  rd,
    input  logic        isLoad,
    input  logic        isStore,
    input  logic        takeBranchIn,
    input  logic [31:0] branchTargetIn,
    output logic        retire,
    output logic        takeBranch,
    output logic [31:0] branchTarget,
    output logic        wbEn,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData
);
    localparam int addrW = $clog2(`DMEM_BYTES);

    logic [7:0]       dmem [0:`DMEM_BYTES-1];
    logic [addrW-1:0] a0, a1, a2, a3;

    // byte lanes, wrap past the top of memory
    assign a0 = result[addrW-1:0];
    assign a1 = a0 + addrW'(1);
    assign a2 = a0 + addrW'(2);
    assign a3 = a0 + addrW'(3);

    // lowest address holds the msb
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_BYTES; i++) dmem[i] <= 8'd0;
        end else if (exValid && isStore) begin
            dmem[a0] <= storeData[31:24];
            dmem[a1] <= storeData[23:16];
            dmem[a2] <= storeData[15:8];
            dmem[a3] <= storeData[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= 1'b0;
            wbEn   <= 1'b0;
        end else begin
            retire <= exValid;
            wbEn   <= exValid && !isStore && (rd != 5'd0);  // branches carry rd 0
        end
    end

    always_ff @(posedge clk) begin
        if (exValid) begin
            wbRd         <= rd;
            wbData       <= isLoad ? {dmem[a0], dmem[a1], dmem[a2], dmem[a3]} : result;
            takeBranch   <= takeBranchIn;
            branchTarget <= branchTargetIn;
        end
    end

endmodule

//--- hw/multicycleCore.sv
`timescale 1ns/1ns

module multicycleCore (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        imemWe,
    input  logic [7:0]  imemAddr,
    input  logic [31:0] imemData,
    input  logic [4:0]  dbgAddr,
    output logic [31:0] dbgData,
    output logic        done,
    output logic [15:0] cycleCount,
    output logic [15:0] instrCount
);
    import riscvPkg::*;

    logic        busy, startGo;
    // fetch to decode
    logic        fetchValid;
    instrT       instr;
    logic [31:0] pc;
    // decode to execute
    logic        decValid, endSeen, dIsLoad, dIsStore, dIsBranch;
    aluOpT       aluOp;
    logic [31:0] opA, opB, dStoreData, dBranchTarget;
    logic [4:0]  dRd;
    // execute to memory
    logic        exValid, eIsLoad, eIsStore, eTakeBranch;
    logic [31:0] result, eStoreData, eBranchTarget;
    logic [4:0]  eRd;
    // memory back to fetch and the register file
    logic        retire, mTakeBranch, wbEn;
    logic [31:0] mBranchTarget, wbData;
    logic [4:0]  wbRd;

    assign startGo = start && !busy;  // ignored mid-program

    fetchStage u_fetch (
        .clk(clk), .rst(rst), .start(startGo), .retire(retire),
        .takeBranch(mTakeBranch), .branchTarget(mBranchTarget),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .fetchValid(fetchValid), .instr(instr), .pc(pc)
    );

    decodeStage u_decode (
        .clk(clk), .rst(rst), .fetchValid(fetchValid), .instr(instr), .pc(pc),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .dbgAddr(dbgAddr), .dbgData(dbgData),
        .decValid(decValid), .endSeen(endSeen), .aluOp(aluOp), .opA(opA), .opB(opB),
        .storeData(dStoreData), .rd(dRd), .isLoad(dIsLoad), .isStore(dIsStore),
        .isBranch(dIsBranch), .branchTarget(dBranchTarget)
    );

    executeStage u_execute (
        .clk(clk), .rst(rst), .decValid(decValid), .aluOp(aluOp), .opA(opA), .opB(opB),
        .storeDataIn(dStoreData), .rdIn(dRd), .isLoadIn(dIsLoad), .isStoreIn(dIsStore),
        .isBranchIn(dIsBranch), .branchTargetIn(dBranchTarget),
        .exValid(exValid), .result(result), .storeData(eStoreData), .rd(eRd),
        .isLoad(eIsLoad), .isStore(eIsStore), .takeBranch(eTakeBranch),
        .branchTarget(eBranchTarget)
    );

    memStage u_mem (
        .clk(clk), .rst(rst), .exValid(exValid), .result(result), .storeData(eStoreData),
        .rd(eRd), .isLoad(eIsLoad), .isStore(eIsStore),
        .takeBranchIn(eTakeBranch), .branchTargetIn(eBranchTarget),
        .retire(retire), .takeBranch(mTakeBranch), .branchTarget(mBranchTarget),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
    );

    // run control, end word seen in decode stops the count
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (startGo) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (endSeen) begin
            busy <= 1'b0;
            done <= 1'b1;  // held until next start
        end
    end

    always_ff @(posedge clk) begin
        if (rst || startGo) begin
            cycleCount <= 16'd0;
            instrCount <= 16'd0;
        end else begin
            if (busy) cycleCount <= cycleCount + 16'd1;  // ends at 4n+2
            if (retire) instrCount <= instrCount + 16'd1;
        end
    end

endmodule

//--- dv/coreTb.sv
`timescale 1ns/1ns
`include "core_consts.svh"

module coreTb;
    localparam int runLimit = 2000;  // cycles allowed per program

    logic        clk;
    logic        rst;
    logic        start;
    logic        imemWe;
    logic [7:0]  imemAddr;
    logic [31:0] imemData;
    logic [4:0]  dbgAddr;
    logic [31:0] dbgData;
    logic        done;
    logic [15:0] cycleCount;
    logic [15:0] instrCount;

    logic [31:0] lfsr;
    logic [31:0] prog [$];  // program words, end word appended on load
    logic [7:0]  memModel [0:`DMEM_BYTES-1];  // big-endian data memory model
    int          errors;
    int          checks;
    int          branchRetired;  // kept for the rerun
    logic [31:0] branchFinal;

    multicycleCore u_dut (
        .clk(clk), .rst(rst), .start(start),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .dbgAddr(dbgAddr), .dbgData(dbgData),
        .done(done), .cycleCount(cycleCount), .instrCount(instrCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] drawBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // assembler helpers
    function automatic logic [31:0] rTypeWord(input logic [6:0] f7,
                                              input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, 3'b000, rd, `OP_R};  // funct3 0 for add, sub, mul
    endfunction

    function automatic logic [31:0] addiWord(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, `OP_IMM};
    endfunction

    function automatic logic [31:0] luiWord(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic logic [31:0] lwWord(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, `F3_LW_SW, rd, `OP_LOAD};
    endfunction

    function automatic logic [31:0] swWord(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `F3_LW_SW, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] bltWord(input logic [4:0] rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, `F3_BLT, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // lui part so that lui + addi of the low 12 bits rebuilds v
    function automatic logic [19:0] upperOf(input logic [31:0] v);
        return v[31:12] + {19'd0, v[11]};
    endfunction

    task automatic storeModel(input logic [7:0] addr, input logic [31:0] val);
        for (int k = 0; k < 4; k++) memModel[addr + 8'(k)] = val[31 - 8*k -: 8];  // msb first
    endtask

    function automatic logic [31:0] loadModel(input logic [7:0] addr);
        return {memModel[addr], memModel[addr + 8'd1], memModel[addr + 8'd2],
                memModel[addr + 8'd3]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic readReg(input logic [4:0] r, output logic [31:0] value);
        @(posedge clk);
        dbgAddr <= r;
        @(negedge clk);  // debug read is combinational
        value = dbgData;
    endtask

    task automatic checkReg(input string name, input logic [4:0] r, input logic [31:0] expected);
        logic [31:0] value;
        readReg(r, value);
        checkValue($sformatf("%s x%0d", name, r), expected, value);
    endtask

    task automatic loadProgram();
        for (int i = 0; i <= prog.size(); i++) begin
            @(posedge clk);
            imemWe   <= 1'b1;
            imemAddr <= 8'(i);
            imemData <= (i < prog.size()) ? prog[i] : `END_WORD;
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    task automatic runProgram(input string name);
        int waited;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        // start just taken, counters cleared and done dropped
        checkValue({name, " done low"}, 32'd0, {31'd0, done});
        checkValue({name, " cycles cleared"}, 32'd0, {16'd0, cycleCount});
        checkValue({name, " instrs cleared"}, 32'd0, {16'd0, instrCount});
        waited = 0;
        while (!done && waited < runLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("%s: timed out waiting for done after %0d cycles", name, waited);
            errors++;
        end
    endtask

    // 4 cycles per instruction plus start and end word
    task automatic checkTiming(input string name, input int retired);
        checkValue({name, " instrCount"}, 32'(retired), {16'd0, instrCount});
        checkValue({name, " cycleCount"}, 32'(4 * retired + 2), {16'd0, cycleCount});
        checkValue({name, " done high"}, 32'd1, {31'd0, done});
    endtask

    task automatic resetStateTest();
        checkValue("reset done", 32'd0, {31'd0, done});
        checkValue("reset cycleCount", 32'd0, {16'd0, cycleCount});
        checkValue("reset instrCount", 32'd0, {16'd0, instrCount});
        for (int r = 0; r < 32; r++) checkReg("reset", 5'(r), 32'd0);
    endtask

    task automatic arithmeticTest();
        logic [11:0] a, b, c;
        logic [19:0] u;
        logic [31:0] want [1:8];
        a = 12'(drawBits(12));
        b = 12'(drawBits(12));
        c = 12'(drawBits(12));
        u = 20'(drawBits(20));
        // 32-bit wrapping model
        want[1] = sext12(a);
        want[2] = sext12(b);
        want[3] = want[1] + sext12(c);
        want[4] = want[1] + want[2];
        want[5] = want[1] - want[2];
        want[6] = want[4] * want[5];
        want[7] = want[6] * want[6];  // wraps
        want[8] = {u, 12'd0} + want[1];
        prog.delete();
        prog.push_back(addiWord(5'd1, 5'd0, a));
        prog.push_back(addiWord(5'd2, 5'd0, b));
        prog.push_back(addiWord(5'd3, 5'd1, c));
        prog.push_back(rTypeWord(7'd0, 5'd4, 5'd1, 5'd2));
        prog.push_back(rTypeWord(`F7_SUB, 5'd5, 5'd1, 5'd2));
        prog.push_back(rTypeWord(`F7_MUL, 5'd6, 5'd4, 5'd5));
        prog.push_back(rTypeWord(`F7_MUL, 5'd7, 5'd6, 5'd6));
        prog.push_back(luiWord(5'd8, u));
        prog.push_back(addiWord(5'd8, 5'd8, a));
        prog.push_back(addiWord(5'd0, 5'd1, 12'd5));  // writes to x0 dropped
        prog.push_back(rTypeWord(7'd0, 5'd0, 5'd1, 5'd2));
        loadProgram();
        runProgram("arith");
        for (int r = 1; r <= 8; r++) checkReg("arith", 5'(r), want[r]);
        checkReg("arith", 5'd0, 32'd0);
        checkTiming("arith", prog.size());
    endtask

    task automatic memoryOrderTest();
        logic [31:0] v, w;
        logic [7:0]  base;
        v    = drawBits(32);
        w    = drawBits(32);
        base = 8'(`DMEM_BYTES - 4);  // top word, base+1 wraps into byte 0
        for (int i = 0; i < `DMEM_BYTES; i++) memModel[i] = 8'd0;
        storeModel(base, v);
        storeModel(8'd0, w);
        prog.delete();
        prog.push_back(luiWord(5'd9, upperOf(v)));
        prog.push_back(addiWord(5'd9, 5'd9, v[11:0]));
        prog.push_back(luiWord(5'd13, upperOf(w)));
        prog.push_back(addiWord(5'd13, 5'd13, w[11:0]));
        prog.push_back(addiWord(5'd10, 5'd0, 12'(base)));
        prog.push_back(swWord(5'd9, 5'd10, 12'd0));
        prog.push_back(swWord(5'd13, 5'd0, 12'd0));
        prog.push_back(lwWord(5'd11, 5'd10, 12'd0));
        prog.push_back(lwWord(5'd12, 5'd10, 12'd1));  // straddles the wrap
        prog.push_back(lwWord(5'd14, 5'd10, 12'd4));  // wraps to address 0
        loadProgram();
        runProgram("memory");
        checkReg("memory", 5'd9, v);
        checkReg("memory", 5'd11, loadModel(base));
        checkReg("memory", 5'd12, loadModel(base + 8'd1));
        checkReg("memory", 5'd14, loadModel(base + 8'd4));
        checkTiming("memory", prog.size());
    endtask

    task automatic branchLoopTest();
        int   limit, cnt, iters;
        logic taken;
        limit = int'(drawBits(3)) + 2;
        // step the loop, blt sits at the bottom so the body runs at least once
        cnt   = -3;
        iters = 0;
        taken = 1'b1;
        while (taken) begin
            cnt   = cnt + 1;
            iters = iters + 1;
            taken = cnt < limit;
        end
        prog.delete();
        prog.push_back(addiWord(5'd20, 5'd0, 12'hFFD));  // counter starts at -3
        prog.push_back(addiWord(5'd21, 5'd0, 12'(limit)));
        prog.push_back(addiWord(5'd22, 5'd0, 12'd0));
        prog.push_back(addiWord(5'd20, 5'd20, 12'd1));  // loop body at 12
        prog.push_back(addiWord(5'd22, 5'd22, 12'd2));
        prog.push_back(bltWord(5'd20, 5'd21, -13'sd8));
        prog.push_back(addiWord(5'd23, 5'd0, 12'd7));
        prog.push_back(addiWord(5'd24, 5'd0, 12'hFFF));
        prog.push_back(bltWord(5'd24, 5'd0, 13'd8));  // -1 < 0 signed, skips next
        prog.push_back(addiWord(5'd25, 5'd0, 12'd99));
        prog.push_back(addiWord(5'd26, 5'd0, 12'd1));
        prog.push_back(bltWord(5'd0, 5'd24, 13'd8));  // 0 < -1 false
        prog.push_back(addiWord(5'd27, 5'd0, 12'd5));
        branchRetired = 3 + 3 * iters + 6;
        branchFinal   = 32'(cnt);
        loadProgram();
        runProgram("branch");
        checkReg("branch", 5'd20, branchFinal);
        checkReg("branch", 5'd22, 32'(2 * iters));
        checkReg("branch", 5'd23, 32'd7);
        checkReg("branch", 5'd24, 32'hFFFF_FFFF);
        checkReg("branch", 5'd25, 32'd0);  // skipped by the taken branch
        checkReg("branch", 5'd26, 32'd1);
        checkReg("branch", 5'd27, 32'd5);
        checkTiming("branch", branchRetired);
    endtask

    // same program again, counters must clear and done toggle
    task automatic rerunTest();
        runProgram("rerun");
        checkTiming("rerun", branchRetired);
        checkReg("rerun", 5'd20, branchFinal);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        lfsr     = 32'h686f;
        rst      = 1'b1;
        start    = 1'b0;
        imemWe   = 1'b0;
        imemAddr = 8'd0;
        imemData = 32'd0;
        dbgAddr  = 5'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        resetStateTest();
        arithmeticTest();
        memoryOrderTest();
        branchLoopTest();
        rerunTest();
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hw/riscvPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memStage.sv
hw/multicycleCore.sv
dv/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module coreTb -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/coreSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qF 'All tests passed!'; then
    exit 0
else
    exit 1
fi
